/* tb.f */
source/alloc_pkg.sv
source/data_ram.sv
source/mem_arbiter.sv
source/free_list.sv
source/write_port.sv
source/read_port.sv
source/bank_alloc_top.sv
tb/bank_alloc_checker.sv
tb/bank_alloc_tb.sv

/* tb/bank_alloc_tb.sv */
`timescale 1ns/1ps

module bank_alloc_tb;
  import alloc_pkg::*;

  localparam logic [2:0] OP_MALLOC = 3'd0;
  localparam logic [2:0] OP_FREE   = 3'd1;
  localparam logic [2:0] OP_WRITE  = 3'd2;
  localparam logic [2:0] OP_READ   = 3'd3;
  localparam logic [2:0] OP_BOTH   = 3'd4;
  localparam int MAX_OPS   = 256;
  localparam int RAND_OPS  = 160;
  // generous bound on the cycles one operation may take
  localparam int OP_CYCLES = 16;

  // one row of the stimulus table
  typedef struct packed {
    logic [2:0] op;
    addr_t      adr;
    data_t      data;
    logic       err;
    logic       pop;
    data_t      exp;
  } op_t;

  logic  clk, rst;
  logic  malloc, ma_vld, ma_fail, alloc_busy;
  bank_t ma_bank;
  addr_t ma_adr;
  logic  dq_vld, dq_err;
  addr_t dq_adr;
  logic  write, wr_bp, wr_err;
  addr_t wr_adr;
  data_t din;
  logic  read, rd_bp, rd_vld, rd_err;
  addr_t rd_adr;
  data_t rd_dout;

  op_t   ops [MAX_OPS];
  int    n_ops;

  // reference model
  logic  map_m   [NUM_ADDRS];
  data_t mem_m   [NUM_ADDRS];
  int    fresh_m [NUM_BANKS];
  row_t  stk     [NUM_BANKS][BANK_ROWS];
  int    sp      [NUM_BANKS];

  bank_alloc_top bank_alloc_top_inst (.*);

  always #20 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // appends one operation with the result the model predicts
  task automatic plan_op(input logic [2:0] op, input addr_t adr, input data_t data);
    op_t   e;
    bank_t b;
    b      = adr[ADDR_BITS-1:ROW_BITS];
    e.op   = op;
    e.adr  = adr;
    e.data = data;
    e.err  = !map_m[adr];
    e.pop  = 1'b0;
    e.exp  = mem_m[adr];
    case (op)
      OP_MALLOC: begin
        e.err = 1'b0;
        e.exp = '0;
        // never used rows first, then last released first
        if (fresh_m[b] < BANK_ROWS) begin
          e.exp[ADDR_BITS-1:0] = {b, fresh_m[b][ROW_BITS-1:0]};
          fresh_m[b] = fresh_m[b] + 1;
        end else if (sp[b] > 0) begin
          sp[b] = sp[b] - 1;
          e.exp[ADDR_BITS-1:0] = {b, stk[b][sp[b]]};
          e.pop = 1'b1;
        end else begin
          e.err = 1'b1;
        end
        if (!e.err) begin
          map_m[e.exp[ADDR_BITS-1:0]] = 1'b1;
        end
      end
      OP_FREE: begin
        if (!e.err) begin
          map_m[adr]    = 1'b0;
          stk[b][sp[b]] = adr[ROW_BITS-1:0];
          sp[b]         = sp[b] + 1;
        end
      end
      OP_READ: begin
      end
      default: begin
        // the write lands before a read accepted with it
        if (!e.err) begin
          mem_m[adr] = data;
          e.exp      = data;
        end
      end
    endcase
    ops[n_ops] = e;
    n_ops++;
  endtask

  task automatic drive_op(input op_t e);
    case (e.op)
      OP_MALLOC: begin
        malloc  <= 1'b1;
        ma_bank <= e.adr[ADDR_BITS-1:ROW_BITS];
        @(posedge clk);
        malloc <= 1'b0;
        @(negedge clk);
        // a reused row spends one cycle reading the link memory
        assert (alloc_busy == e.pop)
          else report_error($sformatf("Fail alloc_busy got %h expected %h",
                                      alloc_busy, e.pop));
        while (!ma_vld && !ma_fail) @(negedge clk);
        assert (ma_fail == e.err)
          else report_error($sformatf("Fail ma_fail got %h expected %h", ma_fail, e.err));
        assert (e.err || ma_adr == e.exp[ADDR_BITS-1:0])
          else report_error($sformatf("Fail ma_adr got %h expected %h", ma_adr,
                                      e.exp[ADDR_BITS-1:0]));
      end
      OP_FREE: begin
        dq_vld <= 1'b1;
        dq_adr <= e.adr;
        @(posedge clk);
        dq_vld <= 1'b0;
        @(negedge clk);
        assert (dq_err == e.err)
          else report_error($sformatf("Fail dq_err got %h expected %h", dq_err, e.err));
      end
      default: begin
        if (e.op != OP_READ) begin
          write  <= 1'b1;
          wr_adr <= e.adr;
          din    <= e.data;
        end
        if (e.op != OP_WRITE) begin
          read   <= 1'b1;
          rd_adr <= e.adr;
        end
        @(negedge clk);
        while ((write && wr_bp) || (read && rd_bp)) @(negedge clk);
        @(posedge clk);
        write <= 1'b0;
        read  <= 1'b0;
        @(negedge clk);
        if (e.op != OP_READ) begin
          assert (wr_err == e.err)
            else report_error($sformatf("Fail wr_err got %h expected %h", wr_err, e.err));
        end
        if (e.op != OP_WRITE) begin
          while (!rd_vld) @(negedge clk);
          assert (rd_err == e.err)
            else report_error($sformatf("Fail rd_err got %h expected %h", rd_err, e.err));
          // rows never written hold no known value
          assert ($isunknown(e.exp) || rd_dout == e.exp)
            else report_error($sformatf("Fail rd_dout got %h expected %h", rd_dout, e.exp));
        end
      end
    endcase
  endtask

  initial begin
    int unsigned r;
    addr_t       a;
    r       = $urandom(32'hd3ed);
    clk     = 1'b0;
    rst     = 1'b1;
    malloc  = 1'b0;
    ma_bank = '0;
    dq_vld  = 1'b0;
    dq_adr  = '0;
    write   = 1'b0;
    wr_adr  = '0;
    din     = '0;
    read    = 1'b0;
    rd_adr  = '0;
    n_ops   = 0;
    for (int i = 0; i < NUM_ADDRS; i++) map_m[i] = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      fresh_m[i] = 0;
      sp[i]      = 0;
    end

    // every row of bank 1, then one too many
    repeat (BANK_ROWS + 1) plan_op(OP_MALLOC, 6'h10, '0);
    plan_op(OP_FREE, 6'h13, '0);
    plan_op(OP_FREE, 6'h17, '0);
    plan_op(OP_FREE, 6'h1c, '0);
    repeat (4) plan_op(OP_MALLOC, 6'h10, '0);
    a = 6'h10;
    repeat (4) begin
      plan_op(OP_WRITE, a, {4'ha, 6'h0, a});
      plan_op(OP_READ, a, '0);
      a = a + 1'b1;
    end
    plan_op(OP_BOTH, 6'h15, 16'h1234);
    // released address must refuse access and a second release
    plan_op(OP_FREE, 6'h15, '0);
    plan_op(OP_WRITE, 6'h15, 16'hdead);
    plan_op(OP_READ, 6'h15, '0);
    plan_op(OP_FREE, 6'h15, '0);

    repeat (RAND_OPS) begin
      r = $urandom;
      a = r[ADDR_BITS-1:0];
      // steer toward an allocated address when there is one
      for (int k = 0; k < NUM_ADDRS && !map_m[a]; k++) a = a + 1'b1;
      case (r[10:8])
        3'd0, 3'd1: plan_op(OP_MALLOC, {r[7:6], 4'h0}, '0);
        3'd2:       plan_op(OP_FREE, a, '0);
        3'd3, 3'd4: plan_op(OP_WRITE, a, r[31:16]);
        3'd5, 3'd6: plan_op(OP_READ, a, '0);
        default:    plan_op(OP_BOTH, a, r[31:16]);
      endcase
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      @(posedge clk);
      drive_op(ops[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #1;
    #((n_ops * OP_CYCLES + 16) * 40);
    $display("timeout, the DUT stopped responding");
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule

/* tb/bank_alloc_checker.sv */
`timescale 1ns/1ps

module bank_alloc_checker (
  input logic clk,
  input logic rst,
  input logic malloc,
  input logic dq_vld,
  input logic alloc_busy,
  input logic wr_req,
  input logic wr_gnt,
  input logic rd_req,
  input logic rd_gnt,
  input logic read,
  input logic rd_bp,
  input logic rd_vld
);

  // a read was accepted and its data has not come back yet
  logic rd_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_open <= 1'b0;
    end else if (read && !rd_bp) begin
      rd_open <= 1'b1;
    end else if (rd_vld) begin
      rd_open <= 1'b0;
    end
  end

  // no new request while the link memory is being read
  assert property (@(posedge clk) disable iff (rst) alloc_busy |-> !(malloc || dq_vld))
    else $error("malloc or dequeue driven while the allocator is busy");

  assert property (@(posedge clk) disable iff (rst) !(wr_gnt && rd_gnt))
    else $error("write and read granted in the same cycle");

  assert property (@(posedge clk) disable iff (rst) wr_gnt |-> wr_req)
    else $error("write grant without a write request");

  assert property (@(posedge clk) disable iff (rst) rd_gnt |-> rd_req)
    else $error("read grant without a read request");

  // every valid answers a read accepted at the port
  assert property (@(posedge clk) disable iff (rst) rd_vld |-> rd_open)
    else $error("read valid without an earlier accepted read");

endmodule

bind bank_alloc_top bank_alloc_checker bank_alloc_checker_inst (
  .clk        (clk),
  .rst        (rst),
  .malloc     (malloc),
  .dq_vld     (dq_vld),
  .alloc_busy (alloc_busy),
  .wr_req     (wr_req),
  .wr_gnt     (wr_gnt),
  .rd_req     (rd_req),
  .rd_gnt     (rd_gnt),
  .read       (read),
  .rd_bp      (rd_bp),
  .rd_vld     (rd_vld)
);

/* source/bank_alloc_top.sv */
`timescale 1ns/1ps

module bank_alloc_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             malloc,
  input  alloc_pkg::bank_t ma_bank,
  output logic             ma_vld,
  output alloc_pkg::addr_t ma_adr,
  output logic             ma_fail,
  input  logic             dq_vld,
  input  alloc_pkg::addr_t dq_adr,
  output logic             dq_err,
  output logic             alloc_busy,
  input  logic             write,
  input  alloc_pkg::addr_t wr_adr,
  input  alloc_pkg::data_t din,
  output logic             wr_bp,
  output logic             wr_err,
  input  logic             read,
  input  alloc_pkg::addr_t rd_adr,
  output logic             rd_bp,
  output logic             rd_vld,
  output alloc_pkg::data_t rd_dout,
  output logic             rd_err
);
  import alloc_pkg::*;

  logic [NUM_ADDRS-1:0] alloc_map;

  // port to arbiter
  logic  wr_req;
  logic  wr_gnt;
  addr_t wr_adr_q;
  data_t wr_data_q;
  logic  rd_req;
  logic  rd_gnt;
  addr_t rd_adr_q;

  // arbiter to sram
  logic  ram_en;
  logic  ram_we;
  addr_t ram_adr;
  data_t ram_wdata;
  data_t ram_rdata;

  free_list free_list_inst (
    .clk        (clk),
    .rst        (rst),
    .malloc     (malloc),
    .ma_bank    (ma_bank),
    .dq_vld     (dq_vld),
    .dq_adr     (dq_adr),
    .ma_vld     (ma_vld),
    .ma_adr     (ma_adr),
    .ma_fail    (ma_fail),
    .dq_err     (dq_err),
    .alloc_busy (alloc_busy),
    .alloc_map  (alloc_map)
  );

  write_port write_port_inst (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .alloc_map (alloc_map),
    .wr_gnt    (wr_gnt),
    .wr_bp     (wr_bp),
    .wr_err    (wr_err),
    .wr_req    (wr_req),
    .wr_adr_q  (wr_adr_q),
    .wr_data_q (wr_data_q)
  );

  read_port read_port_inst (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .rd_adr    (rd_adr),
    .alloc_map (alloc_map),
    .rd_gnt    (rd_gnt),
    .ram_rdata (ram_rdata),
    .rd_bp     (rd_bp),
    .rd_req    (rd_req),
    .rd_adr_q  (rd_adr_q),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_err    (rd_err)
  );

  mem_arbiter mem_arbiter_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .wr_adr_q  (wr_adr_q),
    .rd_adr_q  (rd_adr_q),
    .wr_data_q (wr_data_q),
    .wr_gnt    (wr_gnt),
    .rd_gnt    (rd_gnt),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_adr   (ram_adr),
    .ram_wdata (ram_wdata)
  );

  data_ram data_ram_inst (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .adr   (ram_adr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

/* source/read_port.sv */
`timescale 1ns/1ps

module read_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            read,
  input  alloc_pkg::addr_t                rd_adr,
  input  logic [alloc_pkg::NUM_ADDRS-1:0] alloc_map,
  input  logic                            rd_gnt,
  input  alloc_pkg::data_t                ram_rdata,
  output logic                            rd_bp,
  output logic                            rd_req,
  output alloc_pkg::addr_t                rd_adr_q,
  output logic                            rd_vld,
  output alloc_pkg::data_t                rd_dout,
  output logic                            rd_err
);

  // waiting for grant
  logic pend;
  // granted, sram data due next cycle
  logic lat;
  logic err_q;
  logic take;

  assign rd_bp  = pend || lat;
  assign rd_req = pend;
  assign take   = read && !rd_bp;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend   <= 1'b0;
      lat    <= 1'b0;
      rd_vld <= 1'b0;
      rd_err <= 1'b0;
    end else begin
      if (take) begin
        pend <= 1'b1;
      end else if (rd_gnt) begin
        pend <= 1'b0;
      end
      lat    <= rd_gnt;
      rd_vld <= lat;
      rd_err <= lat && err_q;
    end
  end

  // map bit is sampled once, when the read is accepted
  always_ff @(posedge clk) begin
    if (take) begin
      rd_adr_q <= rd_adr;
      err_q    <= !alloc_map[rd_adr];
    end
    if (lat) begin
      rd_dout <= ram_rdata;
    end
  end

endmodule

/* source/write_port.sv */
`timescale 1ns/1ps

module write_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            write,
  input  alloc_pkg::addr_t                wr_adr,
  input  alloc_pkg::data_t                din,
  input  logic [alloc_pkg::NUM_ADDRS-1:0] alloc_map,
  input  logic                            wr_gnt,
  output logic                            wr_bp,
  output logic                            wr_err,
  output logic                            wr_req,
  output alloc_pkg::addr_t                wr_adr_q,
  output alloc_pkg::data_t                wr_data_q
);

  logic pend;
  logic take;

  // a granted slot frees up in the same cycle
  assign wr_bp  = pend && !wr_gnt;
  assign wr_req = pend;
  assign take   = write && !wr_bp;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend   <= 1'b0;
      wr_err <= 1'b0;
    end else begin
      wr_err <= take && !alloc_map[wr_adr];
      // unallocated writes are dropped here
      if (take) begin
        pend <= alloc_map[wr_adr];
      end else if (wr_gnt) begin
        pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      wr_adr_q  <= wr_adr;
      wr_data_q <= din;
    end
  end

endmodule

/* source/free_list.sv */
`timescale 1ns/1ps

module free_list (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             malloc,
  input  alloc_pkg::bank_t                 ma_bank,
  input  logic                             dq_vld,
  input  alloc_pkg::addr_t                 dq_adr,
  output logic                             ma_vld,
  output alloc_pkg::addr_t                 ma_adr,
  output logic                             ma_fail,
  output logic                             dq_err,
  output logic                             alloc_busy,
  output logic [alloc_pkg::NUM_ADDRS-1:0]  alloc_map
);
  import alloc_pkg::*;

  alloc_state_t state;
  bank_t        pop_bank;

  // per bank bookkeeping
  fill_t        fresh_cnt [NUM_BANKS];
  fill_t        reuse_cnt [NUM_BANKS];
  row_t         head      [NUM_BANKS];

  // next pointer of every released row, indexed by flat address
  row_t         link_mem  [NUM_ADDRS];

  logic         ma_take;
  logic         dq_take;
  logic         has_fresh;
  logic         has_reuse;
  bank_t        dq_bank;
  row_t         dq_row;
  row_t         pop_row;
  row_t         pop_next;
  addr_t        fresh_adr;
  addr_t        pop_adr;

  assign alloc_busy = (state == ALLOC_POP);
  assign ma_take    = malloc && !alloc_busy;
  assign dq_take    = dq_vld && !alloc_busy;

  // msb of the fresh counter set means every row was handed out once
  assign has_fresh = !fresh_cnt[ma_bank][ROW_BITS];
  assign has_reuse = (reuse_cnt[ma_bank] != '0);
  assign fresh_adr = {ma_bank, fresh_cnt[ma_bank][ROW_BITS-1:0]};

  assign dq_bank = dq_adr[ADDR_BITS-1:ROW_BITS];
  assign dq_row  = dq_adr[ROW_BITS-1:0];

  assign pop_row  = head[pop_bank];
  assign pop_adr  = {pop_bank, pop_row};
  assign pop_next = link_mem[pop_adr];

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ALLOC_IDLE;
      ma_vld    <= 1'b0;
      ma_fail   <= 1'b0;
      dq_err    <= 1'b0;
      alloc_map <= '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        fresh_cnt[b] <= '0;
        reuse_cnt[b] <= '0;
        head[b]      <= '0;
      end
    end else begin
      ma_vld  <= 1'b0;
      ma_fail <= 1'b0;
      dq_err  <= 1'b0;

      // release pushes the row on top of its bank's reuse stack
      if (dq_take) begin
        if (alloc_map[dq_adr]) begin
          alloc_map[dq_adr]  <= 1'b0;
          head[dq_bank]      <= dq_row;
          reuse_cnt[dq_bank] <= reuse_cnt[dq_bank] + 1'b1;
        end else begin
          dq_err <= 1'b1;
        end
      end

      case (state)
        ALLOC_IDLE: begin
          if (ma_take) begin
            if (has_fresh) begin
              ma_vld               <= 1'b1;
              alloc_map[fresh_adr] <= 1'b1;
              fresh_cnt[ma_bank]   <= fresh_cnt[ma_bank] + 1'b1;
            end else if (has_reuse) begin
              state <= ALLOC_POP;
            end else begin
              ma_fail <= 1'b1;
            end
          end
        end
        ALLOC_POP: begin
          // a push in the accept cycle already moved head, so that row goes out first
          ma_vld              <= 1'b1;
          alloc_map[pop_adr]  <= 1'b1;
          head[pop_bank]      <= pop_next;
          reuse_cnt[pop_bank] <= reuse_cnt[pop_bank] - 1'b1;
          state               <= ALLOC_IDLE;
        end
        default: state <= ALLOC_IDLE;
      endcase
    end
  end

  // old head becomes the successor of the released row
  always_ff @(posedge clk) begin
    if (dq_take && alloc_map[dq_adr]) begin
      link_mem[dq_adr] <= head[dq_bank];
    end
  end

  always_ff @(posedge clk) begin
    if (ma_take) begin
      pop_bank <= ma_bank;
    end
    if (state == ALLOC_POP) begin
      ma_adr <= pop_adr;
    end else if (ma_take) begin
      ma_adr <= fresh_adr;
    end
  end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_req,
  input  logic             rd_req,
  input  alloc_pkg::addr_t wr_adr_q,
  input  alloc_pkg::addr_t rd_adr_q,
  input  alloc_pkg::data_t wr_data_q,
  output logic             wr_gnt,
  output logic             rd_gnt,
  output logic             ram_en,
  output logic             ram_we,
  output alloc_pkg::addr_t ram_adr,
  output alloc_pkg::data_t ram_wdata
);

  // write grants given while a read was waiting
  logic [1:0] wr_run;
  logic       starve;

  // only the first counted write can be as old as the waiting read
  assign starve = rd_req && (wr_run == 2'd2);
  assign wr_gnt = wr_req && !starve;
  assign rd_gnt = rd_req && !wr_gnt;

  assign ram_en    = wr_gnt || rd_gnt;
  assign ram_we    = wr_gnt;
  assign ram_adr   = wr_gnt ? wr_adr_q : rd_adr_q;
  assign ram_wdata = wr_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_run <= 2'd0;
    end else if (!rd_req || rd_gnt) begin
      wr_run <= 2'd0;
    end else if (wr_gnt && (wr_run != 2'd2)) begin
      wr_run <= wr_run + 2'd1;
    end
  end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  alloc_pkg::addr_t adr,
  input  alloc_pkg::data_t wdata,
  output alloc_pkg::data_t rdata
);
  import alloc_pkg::*;

  data_t mem [NUM_ADDRS];

  // single port, read data shows up the cycle after en
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[adr] <= wdata;
      end else begin
        rdata <= mem[adr];
      end
    end
  end

endmodule

/* source/alloc_pkg.sv */
package alloc_pkg;

  // data word
  localparam int DATA_WIDTH = 16;

  // bank and row geometry
  localparam int NUM_BANKS = 4;
  localparam int BANK_BITS = 2;
  localparam int BANK_ROWS = 16;
  localparam int ROW_BITS  = 4;

  // flat address is {bank, row}
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS;
  localparam int NUM_ADDRS = NUM_BANKS * BANK_ROWS;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [BANK_BITS-1:0]  bank_t;

  // row inside a bank, also used as a link pointer
  typedef logic [ROW_BITS-1:0]   row_t;

  // one bit wider than a row so a full bank count fits
  typedef logic [ROW_BITS:0]     fill_t;

  // pop takes an extra cycle to read the link memory
  typedef enum logic {
    ALLOC_IDLE,
    ALLOC_POP
  } alloc_state_t;

endpackage
